/* files.f */
+incdir+hw
hw/rcc_pkg.sv
hw/en_as_clk_gating.sv
hw/sync_reset_clk_gate.sv
hw/per_clk_rst_control.sv
hw/rcc_per_top.sv
test/tb_clk_gen.sv
test/rcc_per_assertions.sv
test/rcc_per_tb.sv

/* Makefile */
# Verilator lint and simulation of the rcc peripheral slice

VERILATOR := verilator
TOP       := rcc_per_tb
FILELIST  := files.f
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, the exit status of the pipe does not
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "sim: pass" || (echo "sim: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/rcc_per_testdata.txt */
// valid tm trn arcg dom(sys,d1,d2) sft[2:0] en0 en1 en2 lp exp_rst[2:0] exp_run[2:0]
// en = c1_en c1_lpen c2_en c2_lpen amen, lp = c1_sl c1_ds c2_sl c2_ds d3_ds
1_0_1_1_111_111_00000_10000_10000_00000_111_111
1_0_1_1_011_111_00000_10000_10000_00000_000_000
1_0_1_1_111_111_00000_10000_10000_00000_111_111
1_0_1_1_101_111_00000_10000_10000_00000_110_110
1_0_1_1_110_111_00000_10000_10000_00000_101_101
1_0_1_1_111_011_00000_10000_10000_00000_011_011
1_0_1_1_111_111_00000_00000_00000_00000_111_001
1_0_1_1_111_111_00000_00100_00000_00000_111_011
1_0_1_1_111_111_00000_10000_00000_10000_111_000
1_0_1_1_111_111_01000_11000_00000_10000_111_011
1_0_1_1_111_111_01000_11000_00000_11000_111_000
1_0_1_1_111_111_00000_00100_00000_00100_111_001
1_0_1_1_111_111_00000_00110_00000_00100_111_011
1_0_1_1_111_111_11111_11111_00001_11110_111_100
1_0_1_1_111_111_11111_11111_00001_11111_111_000
1_1_1_1_111_111_11111_11111_00001_11111_111_111
1_1_0_1_111_111_11111_11111_00001_11111_000_111
1_0_1_1_011_111_00000_10000_10000_00000_000_000
1_0_1_1_111_111_00000_10000_10000_00000_111_111
1_0_1_0_011_111_00000_10000_10000_00000_000_111
1_0_1_0_111_111_00000_00000_00000_10000_111_000
1_0_1_1_111_111_00000_10000_10000_00000_111_111

/* test/rcc_per_tb.sv */
// rcc peripheral slice testbench that replays the vector file and checks resets and gated clocks
`timescale 1ns/1ps
`include "rcc_params.svh"

module rcc_per_tb;
  import rcc_pkg::*;

  localparam int VEC_W     = 36;
  localparam int MAX_VEC   = 64;
  localparam int SETTLE    = 8;
  localparam int WINDOW    = 8;
  localparam int RST_LIMIT = 20;

  logic                     bus_clk;
  logic                     gen_rst_n;
  logic                     sys_rst_n;
  logic                     d1_rst_n;
  logic                     d2_rst_n;
  per_vec_t                 sft_rst_n;
  per_en_t [`RCC_N_PER-1:0] per_en;
  lp_state_t                lp_state;
  logic                     arcg_on;
  logic                     testmode;
  logic                     test_rst_n;
  per_vec_t                 per_rst_n;
  logic [1:0]               per0_clks;
  logic                     per1_clks;
  logic                     per2_clks;

  // bit 35 marks a valid line
  // field layout as in the data file header
  logic [VEC_W-1:0] vec_mem [0:MAX_VEC-1];

  // free-running gated edge counts
  // each window is the difference of two snapshots
  int unsigned p0a_edges = 0;
  int unsigned p0b_edges = 0;
  int unsigned p1_edges = 0;
  int unsigned p2_edges = 0;

  tb_clk_gen u_clk_gen (
    .clk  (bus_clk),
    .rst_n(gen_rst_n)
  );

  // sys reset is the generator's power-on reset and the vector's sys bit
  rcc_per_top u_dut (
    .bus_clk   (bus_clk),
    .rst_n     (gen_rst_n && sys_rst_n),
    .d1_rst_n  (d1_rst_n),
    .d2_rst_n  (d2_rst_n),
    .sft_rst_n (sft_rst_n),
    .per_en    (per_en),
    .lp_state  (lp_state),
    .arcg_on   (arcg_on),
    .testmode  (testmode),
    .test_rst_n(test_rst_n),
    .per_rst_n (per_rst_n),
    .per0_clks (per0_clks),
    .per1_clks (per1_clks),
    .per2_clks (per2_clks)
  );

  bind rcc_per_top rcc_per_assertions u_assert (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .d1_rst_n  (d1_rst_n),
    .d2_rst_n  (d2_rst_n),
    .sft_rst_n (sft_rst_n),
    .arcg_on   (arcg_on),
    .testmode  (testmode),
    .test_rst_n(test_rst_n),
    .per_rst_n (per_rst_n),
    .per0_clks (per0_clks),
    .per1_clks (per1_clks),
    .per2_clks (per2_clks)
  );

  always @(posedge per0_clks[0]) p0a_edges <= p0a_edges + 1;
  always @(posedge per0_clks[1]) p0b_edges <= p0b_edges + 1;
  always @(posedge per1_clks) p1_edges <= p1_edges + 1;
  always @(posedge per2_clks) p2_edges <= p2_edges + 1;

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic check_value(input string what, input int step, input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t ns: step %0d %s got %0h expected %0h",
               $time, step, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge bus_clk);
    end
  endtask

  task automatic wait_reset_release();
    int guard;
    guard = 0;
    while (gen_rst_n !== 1'b1 && guard < RST_LIMIT) begin
      @(posedge bus_clk);
      guard++;
    end
    if (gen_rst_n !== 1'b1) begin
      abort_run("timeout: power-on reset from the clock generator never released");
    end
  endtask

  // drive one vector, let it settle, then check reset and clock activity
  task automatic run_step(input int idx, input logic [VEC_W-1:0] vec);
    per_vec_t    exp_rst;
    per_vec_t    exp_run;
    int unsigned s0a;
    int unsigned s0b;
    int unsigned s1;
    int unsigned s2;
    exp_rst = vec[5:3];
    exp_run = vec[2:0];
    @(posedge bus_clk);
    #1;
    testmode   = vec[34];
    test_rst_n = vec[33];
    arcg_on    = vec[32];
    sys_rst_n  = vec[31];
    d1_rst_n   = vec[30];
    d2_rst_n   = vec[29];
    sft_rst_n  = vec[28:26];
    per_en[0]  = vec[25:21];
    per_en[1]  = vec[20:16];
    per_en[2]  = vec[15:11];
    lp_state   = vec[10:6];
    wait_cycles(SETTLE);
    #1;
    check_value("per_rst_n", idx, int'(per_rst_n), int'(exp_rst));
    s0a = p0a_edges;
    s0b = p0b_edges;
    s1  = p1_edges;
    s2  = p2_edges;
    wait_cycles(WINDOW);
    #1;
    check_value("per0 clk0 running", idx, int'(p0a_edges != s0a), int'(exp_run[0]));
    check_value("per0 clk1 running", idx, int'(p0b_edges != s0b), int'(exp_run[0]));
    check_value("per1 clk running", idx, int'(p1_edges != s1), int'(exp_run[1]));
    check_value("per2 clk running", idx, int'(p2_edges != s2), int'(exp_run[2]));
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    int n_vec;
    testmode   = 1'b0;
    test_rst_n = 1'b1;
    arcg_on    = 1'b1;
    sys_rst_n  = 1'b1;
    d1_rst_n   = 1'b1;
    d2_rst_n   = 1'b1;
    sft_rst_n  = '1;
    per_en     = '0;
    lp_state   = '0;
    // empty slots hold their own index with the valid bit clear
    for (int i = 0; i < MAX_VEC; i++) begin
      vec_mem[i] = VEC_W'(i);
    end
    $readmemb("test/rcc_per_testdata.txt", vec_mem);
    wait_reset_release();
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[n_vec][VEC_W-1] === 1'b1) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      abort_run("no test vectors were read from the data file");
    end else begin
      for (int v = 0; v < n_vec; v++) begin
        run_step(v, vec_mem[v]);
      end
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

/* test/rcc_per_assertions.sv */
// concurrent checks on the rcc slice outputs: reset rules, test reset, reset-release clock hold
`timescale 1ns/1ps
`include "rcc_params.svh"

module rcc_per_assertions (
  input logic              bus_clk,
  input logic              rst_n,
  input logic              d1_rst_n,
  input logic              d2_rst_n,
  input rcc_pkg::per_vec_t sft_rst_n,
  input logic              arcg_on,
  input logic              testmode,
  input logic              test_rst_n,
  input rcc_pkg::per_vec_t per_rst_n,
  input logic [1:0]        per0_clks,
  input logic              per1_clks,
  input logic              per2_clks
);
  import rcc_pkg::*;

  // two low samples, the release sample, then the held-off phases
  localparam int HIST_W = `RCC_CLK_ON_DELAY + 3;

  per_vec_t          rst_rule;
  per_vec_t          clk_seen;
  logic              quiet_now;
  logic              tog0a = 1'b0;
  logic              tog0b = 1'b0;
  logic              tog1 = 1'b0;
  logic              tog2 = 1'b0;
  logic [3:0]        tog_q;
  logic [HIST_W-1:0] quiet_hist;
  logic [HIST_W-1:0] rst_hist [`RCC_N_PER];

  // ==========================================================================
  // reference reset rules
  // ==========================================================================

  assign rst_rule[0] = rst_n && d1_rst_n && sft_rst_n[0];
  assign rst_rule[1] = rst_n && d2_rst_n && sft_rst_n[1];
  // d3 sees neither d1 nor d2 reset
  assign rst_rule[2] = rst_n && sft_rst_n[2];

  // ==========================================================================
  // gated clock activity, read at the falling bus edge
  // ==========================================================================

  // one toggle per gated rising edge, stable by the next falling edge
  always @(posedge per0_clks[0]) tog0a <= !tog0a;
  always @(posedge per0_clks[1]) tog0b <= !tog0b;
  always @(posedge per1_clks) tog1 <= !tog1;
  always @(posedge per2_clks) tog2 <= !tog2;

  // history of the hold conditions and of each peripheral reset
  assign quiet_now = arcg_on && !testmode;

  always_ff @(negedge bus_clk) begin
    tog_q      <= {tog2, tog1, tog0b, tog0a};
    quiet_hist <= {quiet_hist[HIST_W-2:0], quiet_now};
    for (int i = 0; i < `RCC_N_PER; i++) begin
      rst_hist[i] <= {rst_hist[i][HIST_W-2:0], per_rst_n[i]};
    end
  end

  // a high phase happened since the previous falling edge
  assign clk_seen[0] = (tog0a != tog_q[0]) || (tog0b != tog_q[1]);
  assign clk_seen[1] = tog1 != tog_q[2];
  assign clk_seen[2] = tog2 != tog_q[3];

  // bit 0 newest; release = high after two lows, within DELAY+1 phases
  function automatic logic recent_release(input logic [HIST_W:0] w);
    logic hit;
    hit = 1'b0;
    for (int m = 0; m <= `RCC_CLK_ON_DELAY + 1; m++) begin
      if (w[m] && !w[m+1] && !w[m+2]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // ==========================================================================
  // properties
  // ==========================================================================

  a_rst_rule: assert property (@(posedge bus_clk) !testmode |-> per_rst_n == rst_rule)
    else $error("per_rst_n differs from the domain reset rule");

  a_test_rst: assert property (@(posedge bus_clk)
    testmode |-> per_rst_n == {`RCC_N_PER{test_rst_n}})
    else $error("per_rst_n does not follow test_rst_n in test mode");

  for (genvar i = 0; i < `RCC_N_PER; i++) begin : g_hold
    a_hold: assert property (@(negedge bus_clk)
      (clk_seen[i] && quiet_now && (&quiet_hist)) |->
        !recent_release({rst_hist[i], per_rst_n[i]}))
      else $error("gated clock edge inside the reset-release hold window");
  end

endmodule

/* test/tb_clk_gen.sv */
// testbench clock and reset source: 8 ns bus clock, reset held low for the first 3 cycles
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD     = 8.0,
  parameter int  RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  // release just after an edge, like every other driven input
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

/* hw/rcc_per_top.sv */
// rcc peripheral slice top: clock and reset control for one peripheral in each of d1, d2, d3
`timescale 1ns/1ps
`include "rcc_params.svh"

module rcc_per_top (
  input  logic                              bus_clk,
  input  logic                              rst_n,
  input  logic                              d1_rst_n,
  input  logic                              d2_rst_n,
  input  rcc_pkg::per_vec_t                 sft_rst_n,
  input  rcc_pkg::per_en_t [`RCC_N_PER-1:0] per_en,
  input  rcc_pkg::lp_state_t                lp_state,
  input  logic                              arcg_on,
  input  logic                              testmode,
  input  logic                              test_rst_n,
  output rcc_pkg::per_vec_t                 per_rst_n,
  output logic [1:0]                        per0_clks,
  output logic                              per1_clks,
  output logic                              per2_clks
);
  import rcc_pkg::*;

  // reset inputs bundled for every control
  dom_rst_t rst_in;

  assign rst_in.sys_rst_n = rst_n;
  assign rst_in.d1_rst_n  = d1_rst_n;
  assign rst_in.d2_rst_n  = d2_rst_n;

  // ==========================================================================
  // peripheral controls
  // ==========================================================================

  // d1, two bus clocks, owned by cpu1
  per_clk_rst_control #(
    .BUS_CLK_NUM     (2),
    .ASSIGNED_TO_CPU1(1),
    .SUPPORT_LPEN    (1),
    .DOMAIN          (1)
  ) u_per0 (
    .bus_clks    ({2{bus_clk}}),
    .en          (per_en[0]),
    .lp          (lp_state),
    .rst_in      (rst_in),
    .sft_rst_n   (sft_rst_n[0]),
    .arcg_on     (arcg_on),
    .testmode    (testmode),
    .test_rst_n  (test_rst_n),
    .per_bus_clks(per0_clks),
    .per_rst_n   (per_rst_n[0])
  );

  // d2, needs an explicit enable from either cpu
  per_clk_rst_control #(
    .SUPPORT_LPEN(1),
    .DOMAIN      (2)
  ) u_per1 (
    .bus_clks    (bus_clk),
    .en          (per_en[1]),
    .lp          (lp_state),
    .rst_in      (rst_in),
    .sft_rst_n   (sft_rst_n[1]),
    .arcg_on     (arcg_on),
    .testmode    (testmode),
    .test_rst_n  (test_rst_n),
    .per_bus_clks(per1_clks),
    .per_rst_n   (per_rst_n[1])
  );

  // d3, autonomous mode
  per_clk_rst_control #(
    .SUPPORT_AMEN(1),
    .DOMAIN      (3)
  ) u_per2 (
    .bus_clks    (bus_clk),
    .en          (per_en[2]),
    .lp          (lp_state),
    .rst_in      (rst_in),
    .sft_rst_n   (sft_rst_n[2]),
    .arcg_on     (arcg_on),
    .testmode    (testmode),
    .test_rst_n  (test_rst_n),
    .per_bus_clks(per2_clks),
    .per_rst_n   (per_rst_n[2])
  );

endmodule

/* hw/per_clk_rst_control.sv */
// per-peripheral bus clock gating and reset generation for one power domain
`timescale 1ns/1ps
`include "rcc_params.svh"

module per_clk_rst_control #(
  parameter int BUS_CLK_NUM       = 1,
  parameter int SUPPORT_LPEN      = 0,
  parameter int SUPPORT_AMEN      = 0,
  parameter int D3_DEFAULT_NO_CLK = 0,  // d3 only, no clock unless amen
  parameter int ASSIGNED_TO_CPU1  = 0,
  parameter int ASSIGNED_TO_CPU2  = 0,
  parameter int DOMAIN            = 1   // 1, 2 or 3
) (
  input  logic [BUS_CLK_NUM-1:0] bus_clks,
  input  rcc_pkg::per_en_t       en,
  input  rcc_pkg::lp_state_t     lp,
  input  rcc_pkg::dom_rst_t      rst_in,
  input  logic                   sft_rst_n,
  input  logic                   arcg_on,
  input  logic                   testmode,
  input  logic                   test_rst_n,
  output logic [BUS_CLK_NUM-1:0] per_bus_clks,
  output logic                   per_rst_n
);

  logic c1_lp_ok;
  logic c2_lp_ok;
  logic c1_clk_en;
  logic c2_clk_en;
  logic d3_clk_en;
  logic arcg_clk_en;
  logic bus_clk_en;
  logic func_rst_n;

  // ==========================================================================
  // clock enable terms
  // ==========================================================================

  // sleep stops the clock unless that cpu's lpen is set
  generate
    if (SUPPORT_LPEN == 1) begin : g_lpen
      assign c1_lp_ok = !lp.c1_sleep || en.c1_lpen;
      assign c2_lp_ok = !lp.c2_sleep || en.c2_lpen;
    end else begin : g_no_lpen
      // sleep has no effect here
      assign c1_lp_ok = 1'b1;
      assign c2_lp_ok = 1'b1;
    end
  endgenerate

  // cpu1 term, implicit assignment stands in for c1_en
  generate
    if (ASSIGNED_TO_CPU1 == 1) begin : g_cpu1_asg
      assign c1_clk_en = c1_lp_ok && !lp.c1_deepsleep;
    end else begin : g_cpu1_reg
      assign c1_clk_en = en.c1_en && c1_lp_ok && !lp.c1_deepsleep;
    end
  endgenerate

  // cpu2 term, same shape
  generate
    if (ASSIGNED_TO_CPU2 == 1) begin : g_cpu2_asg
      assign c2_clk_en = c2_lp_ok && !lp.c2_deepsleep;
    end else begin : g_cpu2_reg
      assign c2_clk_en = en.c2_en && c2_lp_ok && !lp.c2_deepsleep;
    end
  endgenerate

  // d3 autonomous term, keeps d3 alive with both cpus stopped
  generate
    if (DOMAIN == 3) begin : g_d3
      if (SUPPORT_AMEN == 1) begin : g_amen
        assign d3_clk_en = en.amen && !lp.d3_deepsleep;
      end else if (D3_DEFAULT_NO_CLK == 1) begin : g_d3_off
        assign d3_clk_en = 1'b0;
      end else begin : g_d3_dflt
        // runs by default until d3 itself stops
        assign d3_clk_en = !lp.d3_deepsleep;
      end
    end else begin : g_d12
      assign d3_clk_en = 1'b0;
    end
  endgenerate

  // ==========================================================================
  // reset-release hold and clock gates
  // ==========================================================================

  // hold runs on the first bus clock
  sync_reset_clk_gate #(
    .DELAY(`RCC_CLK_ON_DELAY)
  ) u_sync_reset_clk_gate (
    .clk    (bus_clks[0]),
    .rst_n  (per_rst_n),
    .arcg_on(arcg_on),
    .clk_en (arcg_clk_en)
  );

  assign bus_clk_en = (c1_clk_en || c2_clk_en || d3_clk_en) && arcg_clk_en;

  // one gate cell per bus clock, testmode forces all on
  generate
    for (genvar i = 0; i < BUS_CLK_NUM; i++) begin : g_gate
      en_as_clk_gating u_gate (
        .raw_clk(bus_clks[i]),
        .active (bus_clk_en),
        .bypass (testmode),
        .gen_clk(per_bus_clks[i])
      );
    end
  endgenerate

  // ==========================================================================
  // peripheral reset
  // ==========================================================================

  // sys and sw reset always, plus own domain reset
  // d3 ignores the d1/d2 resets
  generate
    if (DOMAIN == 1) begin : g_rst_d1
      assign func_rst_n = rst_in.sys_rst_n && rst_in.d1_rst_n && sft_rst_n;
    end else if (DOMAIN == 2) begin : g_rst_d2
      assign func_rst_n = rst_in.sys_rst_n && rst_in.d2_rst_n && sft_rst_n;
    end else begin : g_rst_d3
      assign func_rst_n = rst_in.sys_rst_n && sft_rst_n;
    end
  endgenerate

  // test reset mux
  assign per_rst_n = testmode ? test_rst_n : func_rst_n;

endmodule

/* hw/sync_reset_clk_gate.sv */
// reset-release clock hold: keeps clk_en off until DELAY cycles after reset release
`timescale 1ns/1ps
`include "rcc_params.svh"

module sync_reset_clk_gate #(
  parameter int DELAY = `RCC_CLK_ON_DELAY
) (
  input  logic clk,
  input  logic rst_n,
  input  logic arcg_on,
  output logic clk_en
);
  import rcc_pkg::*;

  localparam int CNT_W = `RCC_DELAY_W;
  // last count value before the clock is released
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DELAY - 1);

  arcg_state_t      state;
  arcg_state_t      state_nxt;
  logic [CNT_W-1:0] cnt;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      ARCG_HOLD: begin
        // zero delay skips the count phase
        state_nxt = (DELAY == 0) ? ARCG_ON : ARCG_COUNT;
      end
      ARCG_COUNT: begin
        if (cnt == CNT_LAST) begin
          state_nxt = ARCG_ON;
        end
      end
      ARCG_ON:  state_nxt = ARCG_ON;
      default:  state_nxt = ARCG_HOLD;
    endcase
  end

  // peripheral reset is sampled synchronously here
  // clk_en follows the next state, so it rises DELAY cycles after release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= ARCG_HOLD;
      cnt    <= '0;
      clk_en <= !arcg_on;
    end else begin
      state  <= state_nxt;
      if (state == ARCG_COUNT) begin
        cnt <= cnt + 1'b1;
      end else begin
        cnt <= '0;
      end
      // gating off means clock free-runs whatever the fsm says
      clk_en <= (state_nxt == ARCG_ON) || !arcg_on;
    end
  end

endmodule

/* hw/en_as_clk_gating.sv */
// glitch-free latch-based clock gate cell with test-mode bypass
`timescale 1ns/1ps

module en_as_clk_gating (
  input  logic raw_clk,
  input  logic active,
  input  logic bypass,
  output logic gen_clk
);

  // enable captured during the low phase
  logic en_lat;

  // latch open only while raw_clk is low
  // so enable changes never cut a high phase short
  always_latch begin
    if (!raw_clk) begin
      en_lat = active | bypass;
    end
  end

  // and gate, safe since en_lat is frozen through the high phase
  assign gen_clk = raw_clk & en_lat;

endmodule

/* hw/rcc_pkg.sv */
// rcc shared types: per-peripheral vectors, enable and low-power structs, gate fsm states
`include "rcc_params.svh"

package rcc_pkg;

  // one bit per peripheral
  // sw resets, per_rst_n outputs, clock-running flags
  typedef logic [`RCC_N_PER-1:0] per_vec_t;

  // register bits of one peripheral, arriving as plain levels
  typedef struct packed {
    logic c1_en;    // cpu1 enable
    logic c1_lpen;  // cpu1 keeps clock in sleep
    logic c2_en;    // cpu2 enable
    logic c2_lpen;  // cpu2 keeps clock in sleep
    logic amen;     // d3 autonomous mode
  } per_en_t;

  // low-power state from the power controller
  typedef struct packed {
    logic c1_sleep;
    logic c1_deepsleep;
    logic c2_sleep;
    logic c2_deepsleep;
    logic d3_deepsleep;
  } lp_state_t;

  // reset inputs, all active low
  typedef struct packed {
    logic sys_rst_n;
    logic d1_rst_n;
    logic d2_rst_n;
  } dom_rst_t;

  // reset-release clock hold fsm
  typedef enum logic [1:0] {
    ARCG_HOLD  = 2'b00,
    ARCG_COUNT = 2'b01,
    ARCG_ON    = 2'b10
  } arcg_state_t;

endpackage

/* hw/rcc_params.svh */
// rcc peripheral slice parameters: peripheral count and reset-release clock hold
`ifndef RCC_PARAMS_SVH
`define RCC_PARAMS_SVH

// ==========================================================================
// peripheral slice sizing
// ==========================================================================

// one peripheral per power domain d1, d2, d3
`define RCC_N_PER 3

// ==========================================================================
// automatic reset clock gating
// ==========================================================================

// bus clock cycles after reset release before the gated clock may run
`define RCC_CLK_ON_DELAY 2

// delay counter width, must hold RCC_CLK_ON_DELAY
`define RCC_DELAY_W 4

`endif
